//--- Bender.yml
package:
  name: audio_loopback

dependencies: {}

sources:
  # Package first, then the blocks, then the top level
  - files:
      - source/audio_pkg.sv
      - source/inmp441_mic_i2s_receiver.sv
      - source/sample_fifo.sv
      - source/i2s_audio_out.sv
      - source/peak_level_meter.sv
      - source/audio_loopback_top.sv

  # Testbench reads test/audio_stim.txt from the project root
  - target: test
    files:
      - test/tb_audio_loopback.sv

//--- audio_loopback_top.f
source/audio_pkg.sv
source/inmp441_mic_i2s_receiver.sv
source/sample_fifo.sv
source/i2s_audio_out.sv
source/peak_level_meter.sv
source/audio_loopback_top.sv
test/tb_audio_loopback.sv

//--- source/audio_loopback_top.sv
// Audio loopback top: INMP441 microphone through a sample FIFO to an I2S DAC, with a level meter
`timescale 1ns/100ps

module audio_loopback_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               sd,
    output logic                               sck,
    output logic                               ws,
    output logic                               mclk,
    output logic                               bclk,
    output logic                               lrclk,
    output logic                               sdata,
    output logic [audio_pkg::meter_leds - 1:0] led,
    output logic                               overflow,
    output logic                               underrun
);

    import audio_pkg::*;

    // ----------------------------------------------------------
    // Microphone side
    // ----------------------------------------------------------

    audio_sample_t mic_sample;
    logic          mic_valid;   // One strobe per frame

    inmp441_mic_i2s_receiver i_microphone (
        .clk          ( clk        ),
        .reset        ( reset      ),
        .sd           ( sd         ),
        .sck          ( sck        ),
        .ws           ( ws         ),
        .sample       ( mic_sample ),
        .sample_valid ( mic_valid  )
    );

    // ----------------------------------------------------------
    // Buffer and DAC side
    // ----------------------------------------------------------

    audio_sample_t head;
    logic          has_data;
    logic          pop;

    sample_fifo i_fifo (
        .clk       ( clk        ),
        .reset     ( reset      ),
        .push      ( mic_valid  ),
        .push_data ( mic_sample ),
        .pop       ( pop        ),
        .head      ( head       ),
        .has_data  ( has_data   ),
        .overflow  ( overflow   ),
        .underrun  ( underrun   )
    );

    i2s_audio_out o_audio (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .head     ( head     ),
        .has_data ( has_data ),
        .pop      ( pop      ),
        .mclk     ( mclk     ),
        .bclk     ( bclk     ),
        .lrclk    ( lrclk    ),
        .sdata    ( sdata    )
    );

    peak_level_meter i_meter (
        .clk          ( clk        ),
        .reset        ( reset      ),
        .sample       ( mic_sample ),  // Taps the receiver directly
        .sample_valid ( mic_valid  ),
        .led          ( led        )
    );

endmodule

//--- source/audio_pkg.sv
// Shared timing constants and the sample type of the audio loopback path, imported by each module
package audio_pkg;

    // ----------------------------------------------------------
    // Serial frame timing, shared by microphone and DAC sides
    // ----------------------------------------------------------

    localparam int sck_half_period = 4;   // Clocks per half period of sck and bclk
    localparam int bits_per_frame  = 64;  // Left half plus right half

    localparam int div_width       = $clog2(sck_half_period);
    localparam int frame_cnt_width = $clog2(bits_per_frame);

    // ----------------------------------------------------------
    // Sample widths and buffering
    // ----------------------------------------------------------

    localparam int mic_width       = 24;  // INMP441 word
    localparam int dac_width       = 16;  // Upper part sent to the DAC

    localparam int fifo_depth      = 4;
    localparam int fifo_ptr_width  = $clog2(fifo_depth);

    // ----------------------------------------------------------
    // Level meter
    // ----------------------------------------------------------

    localparam int meter_window    = 16;  // Samples per peak window
    localparam int meter_leds      = 4;
    localparam int meter_cnt_width = $clog2(meter_window);

    // Entry i lights LED i when the peak reaches it
    localparam logic [meter_leds - 1:0][dac_width - 1:0] meter_thresholds = {
        16'd16384,
        16'd8192,
        16'd4096,
        16'd2048
    };

    // ----------------------------------------------------------
    // Sample carried between receiver, FIFO, DAC and meter
    // ----------------------------------------------------------

    typedef struct packed {
        logic signed [mic_width - 1:0] value;  // Two's complement, MSB first on the wire
    } audio_sample_t;

endpackage

//--- source/i2s_audio_out.sv
// I2S transmitter to an external DAC: pops one sample per frame and sends it on both channels
`timescale 1ns/100ps

module i2s_audio_out (
    input  logic                     clk,
    input  logic                     reset,
    input  audio_pkg::audio_sample_t head,
    input  logic                     has_data,
    output logic                     pop,
    output logic                     mclk,
    output logic                     bclk,
    output logic                     lrclk,
    output logic                     sdata
);

    import audio_pkg::*;

    // ----------------------------------------------------------
    // Master clock, bit clock and frame position
    // ----------------------------------------------------------

    logic [div_width       - 1:0] div_cnt;
    logic [frame_cnt_width - 1:0] bit_cnt;
    logic [frame_cnt_width - 1:0] next_bit;

    logic div_last;
    logic bclk_fall;
    logic frame_end;
    logic running;  // Set once the first frame after reset has started

    assign div_last  = (div_cnt == div_width'(sck_half_period - 1));
    assign bclk_fall = div_last && bclk;
    assign next_bit  = bit_cnt + 1'b1;
    assign frame_end = bclk_fall && (bit_cnt == frame_cnt_width'(bits_per_frame - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
            bit_cnt <= '0;
            running <= 1'b0;
            pop     <= 1'b0;
        end else begin
            mclk <= !mclk;  // clk / 2

            if (div_last) begin
                div_cnt <= '0;
                bclk    <= !bclk;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (bclk_fall)
                bit_cnt <= next_bit;

            running <= 1'b1;
            pop     <= !running || frame_end;  // Same cycle that lrclk falls
        end
    end

    assign lrclk = bit_cnt[frame_cnt_width - 1];

    // ----------------------------------------------------------
    // Frame word and serializer
    // ----------------------------------------------------------

    logic [dac_width - 1:0] word;   // Held for both halves
    logic [dac_width - 1:0] shift;

    always_ff @(posedge clk) begin
        if (pop)
            word <= has_data ? head.value [mic_width - 1 -: dac_width] : '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sdata <= 1'b0;
            shift <= '0;
        end else if (bclk_fall) begin
            // MSB one bit period after each lrclk edge
            if (next_bit [frame_cnt_width - 2:0] == 1)
                { sdata, shift } <= { word, 1'b0 };
            else
                { sdata, shift } <= { shift, 1'b0 };  // Zeros after the 16 bits
        end
    end

endmodule

//--- source/inmp441_mic_i2s_receiver.sv
// INMP441 I2S receiver that drives sck and ws and strobes out each left-channel 24-bit sample
`timescale 1ns/100ps

module inmp441_mic_i2s_receiver (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     sd,
    output logic                     sck,
    output logic                     ws,
    output audio_pkg::audio_sample_t sample,
    output logic                     sample_valid
);

    import audio_pkg::*;

    // ----------------------------------------------------------
    // Serial clock and frame position
    // ----------------------------------------------------------

    logic [div_width       - 1:0] div_cnt;
    logic [frame_cnt_width - 1:0] bit_cnt;  // Serial period within the frame

    logic div_last;
    logic sck_rise;
    logic sck_fall;

    assign div_last = (div_cnt == div_width'(sck_half_period - 1));
    assign sck_rise = div_last && !sck;   // sck goes high on this edge
    assign sck_fall = div_last &&  sck;

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (div_last) begin
                div_cnt <= '0;
                sck     <= !sck;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            if (sck_fall)
                bit_cnt <= bit_cnt + 1'b1;  // Wraps at the end of the frame
        end
    end

    // Low for the left half, high for the right half
    assign ws = bit_cnt[frame_cnt_width - 1];

    // ----------------------------------------------------------
    // Data capture
    // ----------------------------------------------------------

    logic                   in_slot;
    logic [mic_width - 1:0] shift_reg;
    logic                   word_done;

    // One-bit I2S delay, so the MSB sits in serial period 1
    assign in_slot = (bit_cnt != '0)
                  && (bit_cnt <= frame_cnt_width'(mic_width));

    always_ff @(posedge clk) begin
        if (sck_rise && in_slot)
            shift_reg <= { shift_reg [mic_width - 2:0], sd };
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            word_done    <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            word_done    <= sck_rise && (bit_cnt == frame_cnt_width'(mic_width));
            sample_valid <= word_done;  // One cycle after the last bit
        end
    end

    // Output word stays put until the next frame's strobe
    always_ff @(posedge clk) begin
        if (word_done)
            sample.value <= shift_reg;
    end

endmodule

//--- source/peak_level_meter.sv
// Peak level meter: shows the loudest sample of each window as a thermometer LED bar
`timescale 1ns/100ps

module peak_level_meter (
    input  logic                            clk,
    input  logic                            reset,
    input  audio_pkg::audio_sample_t        sample,
    input  logic                            sample_valid,
    output logic [audio_pkg::meter_leds - 1:0] led
);

    import audio_pkg::*;

    logic signed [dac_width       - 1:0] upper;
    logic        [dac_width       - 1:0] mag;
    logic        [dac_width       - 1:0] peak;
    logic        [dac_width       - 1:0] win_max;
    logic        [meter_cnt_width - 1:0] count;

    assign upper = sample.value [mic_width - 1 -: dac_width];

    // Absolute value, most negative code saturates to 32767
    always_comb begin
        if (upper == { 1'b1, { (dac_width - 1) { 1'b0 } } })
            mag = { 1'b0, { (dac_width - 1) { 1'b1 } } };
        else if (upper < 0)
            mag = -upper;
        else
            mag = upper;
    end

    assign win_max = (mag > peak) ? mag : peak;

    always_ff @(posedge clk) begin
        if (reset) begin
            peak  <= '0;
            count <= '0;
            led   <= '0;
        end else if (sample_valid) begin
            if (count == meter_cnt_width'(meter_window - 1)) begin
                for (int i = 0; i < meter_leds; i++)
                    led [i] <= (win_max >= meter_thresholds [i]);
                peak  <= '0;   // Next window starts fresh
                count <= '0;
            end else begin
                peak  <= win_max;
                count <= count + 1'b1;
            end
        end
    end

endmodule

//--- source/sample_fifo.sv
// Small sample FIFO between microphone and DAC, with write and pop strobes and sticky error flags
`timescale 1ns/100ps

module sample_fifo (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     push,
    input  audio_pkg::audio_sample_t push_data,
    input  logic                     pop,
    output audio_pkg::audio_sample_t head,
    output logic                     has_data,
    output logic                     overflow,
    output logic                     underrun
);

    import audio_pkg::*;

    audio_sample_t mem [fifo_depth];

    logic [fifo_ptr_width - 1:0] wr_ptr;
    logic [fifo_ptr_width - 1:0] rd_ptr;
    logic [fifo_ptr_width    :0] count;  // Needs to reach fifo_depth

    logic full;
    logic push_ok;
    logic pop_ok;

    assign full     = (count == (fifo_ptr_width + 1)'(fifo_depth));
    assign has_data = (count != '0);
    assign push_ok  = push && !full;
    assign pop_ok   = pop  && has_data;

    assign head     = mem [rd_ptr];  // Head shown combinationally

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (push_ok)
            mem [wr_ptr] <= push_data;
    end

    // ----------------------------------------------------------
    // Pointers, occupancy and sticky flags
    // ----------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
            underrun <= 1'b0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;

            count <= count + push_ok - pop_ok;

            if (push && full)
                overflow <= 1'b1;    // Write dropped
            if (pop && !has_data)
                underrun <= 1'b1;    // Nothing to hand out
        end
    end

endmodule

//--- test/audio_stim.txt
// Column 1: 24-bit microphone word in hex, sent on the left channel
// Column 2: expected 16-bit DAC word in hex, the upper part of column 1
123456 1234
07ff80 07ff
080000 0800
f80100 f801
f80000 f800
0fffff 0fff
100000 1000
f000ff f000
1fff00 1fff
200001 2000
e00042 e000
3fffff 3fff
c0017f c001
000001 0000
ffffff ffff
00a5c3 00a5
400000 4000
bfff00 bfff
7fffff 7fff
800000 8000
3fff80 3fff
c00000 c000
5a5a5a 5a5a
a5a5a5 a5a5
012345 0123
fedcba fedc
0007ff 0007
fff800 fff8
6789ab 6789
98765f 9876
00ff00 00ff
f0f0f0 f0f0

//--- test/tb_audio_loopback.sv
// Testbench for the audio loopback top: microphone model, DAC deserializer, checks and report
`timescale 1ns/100ps

module tb_audio_loopback;

    import audio_pkg::*;

    localparam int num_words     = 32;
    localparam int tail_words    = 2;    // Zero words expected after the stimulus
    localparam int run_frames    = num_words + 4;
    localparam int edge_timeout  = 4 * sck_half_period;
    localparam int frame_timeout = 2 * bits_per_frame * 2 * sck_half_period + 64;

    logic clk;
    logic reset;
    logic sd;
    logic sck;
    logic ws;
    logic mclk;
    logic bclk;
    logic lrclk;
    logic sdata;
    logic [meter_leds - 1:0] led;
    logic overflow;
    logic underrun;

    int errors;
    int checks;
    int seed;

    logic [mic_width - 1:0] mic_words [$];
    logic [dac_width - 1:0] dac_words [$];   // Expected DAC column

    audio_loopback_top dut (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .sd       ( sd       ),
        .sck      ( sck      ),
        .ws       ( ws       ),
        .mclk     ( mclk     ),
        .bclk     ( bclk     ),
        .lrclk    ( lrclk    ),
        .sdata    ( sdata    ),
        .led      ( led      ),
        .overflow ( overflow ),
        .underrun ( underrun )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    // ----------------------------------------------------------
    // Reporting and expected values
    // ----------------------------------------------------------

    task automatic report_mismatch(input string msg);
        errors++;
        $display("Fail at %0t ns: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("Timeout at %0t ns: the %s never came", $time, what);
    endtask

    // Most negative code saturates like the meter's rule says
    function automatic logic [dac_width - 1:0] magnitude(input logic [dac_width - 1:0] d);
        if (d == 16'h8000)
            return 16'h7fff;
        else if (d[dac_width - 1])
            return ~d + 1'b1;
        else
            return d;
    endfunction

    function automatic logic [meter_leds - 1:0] expected_bar(input int first);
        logic [dac_width - 1:0] peak;
        logic [dac_width - 1:0] mag;
        logic [meter_leds - 1:0] bar;
        peak = '0;
        for (int i = first; i < first + meter_window; i++) begin
            mag = magnitude(dac_words[i]);
            if (mag > peak)
                peak = mag;
        end
        for (int i = 0; i < meter_leds; i++)
            bar[i] = (peak >= meter_thresholds[i]);
        return bar;
    endfunction

    task automatic load_stimulus();
        int fd;
        int n;
        string line;
        logic [mic_width - 1:0] m;
        logic [dac_width - 1:0] d;
        fd = $fopen("test/audio_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file test/audio_stim.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%h %h", m, d) == 2) begin   // Comment lines fail here
                mic_words.push_back(m);
                dac_words.push_back(d);
            end
        end
        $fclose(fd);
        if (mic_words.size() != num_words) begin
            errors++;
            $display("Stimulus file held %0d words instead of %0d", mic_words.size(), num_words);
        end
    endtask

    // ----------------------------------------------------------
    // Edge waits, each with its own limit
    // ----------------------------------------------------------

    task automatic wait_sck_fall(output bit ok);
        logic prev;
        int n;
        prev = sck;
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < edge_timeout) begin
            @(posedge clk);
            #1;
            n++;
            if (prev && !sck)
                ok = 1'b1;
            prev = sck;
        end
        if (!ok)
            report_timeout("falling edge of the microphone sck");
    endtask

    task automatic wait_bclk_rise(output bit ok);
        logic prev;
        int n;
        prev = bclk;
        ok   = 1'b0;
        n    = 0;
        while (!ok && n < edge_timeout) begin
            @(posedge clk);
            #1;
            n++;
            if (!prev && bclk)
                ok = 1'b1;
            prev = bclk;
        end
        if (!ok)
            report_timeout("rising edge of the DAC bclk");
    endtask

    // ----------------------------------------------------------
    // Checks on idle pins and frame shape
    // ----------------------------------------------------------

    task automatic check_idle_outputs();
        checks++;
        assert (!mclk && !bclk && !lrclk && !sdata && !sck && !ws)
        else report_mismatch($sformatf(
            "pins not low in reset: mclk %b bclk %b lrclk %b sdata %b sck %b ws %b",
            mclk, bclk, lrclk, sdata, sck, ws));
    endtask

    task automatic check_frame_shape();
        int n;
        int run;
        int falls;
        int low_periods;
        int high_periods;
        logic prev_sck;
        logic prev_ws;
        logic prev_mclk;
        bit seen;
        prev_ws = ws;
        seen    = 1'b0;
        n       = 0;
        while (!seen && n < frame_timeout) begin   // Line up with a frame start
            @(posedge clk);
            #1;
            n++;
            if (prev_ws && !ws)
                seen = 1'b1;
            prev_ws = ws;
        end
        if (!seen) begin
            report_timeout("falling edge of ws");
            return;
        end
        prev_sck     = sck;
        prev_mclk    = mclk;
        run          = 0;
        falls        = 0;
        low_periods  = 0;
        high_periods = 0;
        n            = 0;
        while (falls < bits_per_frame && n < frame_timeout) begin
            @(posedge clk);
            #1;
            n++;
            run++;
            checks++;
            assert (mclk != prev_mclk)   // clk / 2
            else report_mismatch($sformatf("mclk held at %b for two clocks", mclk));
            prev_mclk = mclk;
            if (sck != prev_sck) begin
                checks++;
                assert (run == sck_half_period)
                else report_mismatch($sformatf("sck half period lasted %0d clocks", run));
                run = 0;
                if (prev_sck) begin
                    falls++;
                    if (prev_ws)
                        high_periods++;
                    else
                        low_periods++;
                end
            end
            prev_sck = sck;
            prev_ws  = ws;
        end
        if (falls < bits_per_frame)
            report_timeout("end of the measured microphone frame");
        checks++;
        assert (low_periods == 32 && high_periods == 32)
        else report_mismatch($sformatf("ws low for %0d and high for %0d sck periods",
                                       low_periods, high_periods));
    endtask

    // ----------------------------------------------------------
    // Microphone model and meter check
    // ----------------------------------------------------------

    task automatic check_meter(input int frame);
        int first;
        first = frame - (meter_window - 1);
        if (dac_words.size() < first + meter_window)
            return;
        checks++;
        assert (led == expected_bar(first))
        else report_mismatch($sformatf("led %b after sample %0d, expected %b",
                                       led, frame + 1, expected_bar(first)));
    endtask

    task automatic drive_microphone();
        int frame;
        int pos;
        int falls;
        bit ok;
        logic prev_ws;
        logic [31:0] rnd;
        logic [mic_width - 1:0] w;
        frame   = 0;
        pos     = 0;
        falls   = 0;
        prev_ws = 1'b0;
        while (frame < run_frames && falls < (run_frames + 1) * bits_per_frame) begin
            wait_sck_fall(ok);
            if (!ok)
                return;
            falls++;
            if (prev_ws && !ws) begin
                frame++;
                pos = 0;
            end else begin
                pos++;
            end
            if (!prev_ws && ws && (frame % meter_window) == meter_window - 1)
                check_meter(frame);   // Window's last strobe is long past
            prev_ws = ws;
            w = (frame < mic_words.size()) ? mic_words[frame] : '0;
            if (!ws && pos >= 1 && pos <= mic_width) begin
                sd = w[mic_width - pos];   // MSB one period after ws falls
            end else begin
                rnd = $random(seed);
                sd  = rnd[0];
            end
        end
        if (frame < run_frames)
            report_timeout("falling edge of ws that ends the microphone frame");
        sd = 1'b0;
    endtask

    // ----------------------------------------------------------
    // DAC deserializer and word checks
    // ----------------------------------------------------------

    task automatic monitor_dac();
        int pos;
        int idx;
        int rises;
        bit ok;
        bit started;
        logic last_lr;
        logic [dac_width - 1:0] shreg;
        logic [dac_width - 1:0] left;
        logic [dac_width - 1:0] expected;
        pos     = -1;
        idx     = 0;
        rises   = 0;
        started = 1'b0;
        last_lr = 1'b0;
        shreg   = '0;
        left    = '0;
        while (idx < num_words + tail_words && rises < (run_frames + 2) * bits_per_frame) begin
            wait_bclk_rise(ok);
            if (!ok)
                return;
            rises++;
            pos     = (lrclk != last_lr) ? 0 : pos + 1;
            last_lr = lrclk;
            if (pos >= 1 && pos <= dac_width)
                shreg = { shreg[dac_width - 2:0], sdata };
            if (pos == dac_width) begin
                if (!lrclk) begin
                    left = shreg;
                end else begin
                    checks++;
                    assert (shreg == left)
                    else report_mismatch($sformatf("right word %h differs from left %h",
                                                   shreg, left));
                    if (left != '0)
                        started = 1'b1;   // Leading frames carry zeros
                    if (started) begin
                        expected = (idx < dac_words.size()) ? dac_words[idx] : '0;
                        checks++;
                        assert (left == expected)
                        else report_mismatch($sformatf("DAC word %0d is %h, expected %h",
                                                       idx, left, expected));
                        idx++;
                    end
                end
            end
        end
        if (idx < num_words + tail_words)
            report_timeout("full set of DAC words");
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------

    initial begin
        errors = 0;
        checks = 0;
        seed   = 32'hf30c;
        reset  = 1'b1;
        sd     = 1'b0;
        load_stimulus();
        @(posedge clk);
        #1;
        check_idle_outputs();
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        fork
            drive_microphone();
            monitor_dac();
            check_frame_shape();
        join
        checks++;
        assert (!overflow) else report_mismatch("overflow flag set with equal rates");
        checks++;
        assert (underrun) else report_mismatch("underrun flag low after the first empty pop");
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
